//--- lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

//////////////////////////////////////////////////
// Data path
//////////////////////////////////////////////////

// Width of the core data word and of the bus
`define LSU_XLEN 32

// Bus transactions that may be outstanding at once
`define LSU_DEPTH 2

//////////////////////////////////////////////////
// Configuration register map
//////////////////////////////////////////////////

// Control word with the halt and misalign-trap fields
`define LSU_CFG_CTRL_ADDR 0
// Monitor status word, write ones to clear
`define LSU_CFG_STAT_ADDR 1

`endif

//--- lsu_pkg.sv
`include "lsu_macros.svh"

package lsu_pkg;

  // Plain vectors for the widths that carry a meaning
  typedef logic [`LSU_XLEN-1:0]   addr_t;
  typedef logic [`LSU_XLEN-1:0]   data_t;
  typedef logic [`LSU_XLEN/8-1:0] be_t;
  // Count of bus transactions in flight, wide enough for the depth
  typedef logic [1:0]             cnt_t;

  // Access size as encoded by the core, same as funct3[1:0]
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Request sequencer states
  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_FIRST,
    LSU_SECOND,
    LSU_WAIT
  } lsu_state_e;

  //////////////////////////////////////////////////
  // Port bundles
  //////////////////////////////////////////////////

  // One load or store from the core
  typedef struct packed {
    logic      we;
    lsu_size_e size;
    logic      sign_ext;
    addr_t     addr;
    data_t     wdata;
  } lsu_req_t;

  // Load data or zero, with the error bit of a trapped access
  typedef struct packed {
    data_t rdata;
    logic  err;
  } lsu_resp_t;

  // Bus address phase, held stable until the grant
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  // Bus response phase
  typedef struct packed {
    logic  rvalid;
    data_t rdata;
  } obi_rsp_t;

  // Control register, halt sits in bit 1 and misalign_trap in bit 0
  typedef struct packed {
    logic halt;
    logic misalign_trap;
  } lsu_cfg_t;

  // Sticky monitor flags, cnt_overflow is bit 2 of the status word
  typedef struct packed {
    logic cnt_overflow;
    logic spurious_rvalid;
    logic halt_violation;
  } mon_flags_t;

  // Shape of the current access, handed from the sequencer to the aligner
  typedef struct packed {
    logic      split;
    logic [1:0] addr_low;
    lsu_size_e size;
    logic      sign_ext;
    logic      we;
  } split_info_t;

endpackage

//--- lsu_cfg_regs.sv
`include "lsu_macros.svh"

module lsu_cfg_regs
  import lsu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cfg_we_i,
  input  logic [1:0] cfg_addr_i,
  input  data_t      cfg_wdata_i,
  input  mon_flags_t flags_i,
  output lsu_cfg_t   cfg_o,
  output mon_flags_t flags_clr_o,
  output data_t      cfg_rdata_o
);

  lsu_cfg_t cfg_q;
  logic     sel_ctrl;
  logic     sel_stat;

  // Address decode shared by the write and the read path
  assign sel_ctrl = (cfg_addr_i == 2'(`LSU_CFG_CTRL_ADDR));
  assign sel_stat = (cfg_addr_i == 2'(`LSU_CFG_STAT_ADDR));

  //////////////////////////////////////////////////
  // Control register
  //////////////////////////////////////////////////

  // Both fields come straight from the low bits of the write data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (cfg_we_i && sel_ctrl) begin
      cfg_q <= lsu_cfg_t'(cfg_wdata_i[$bits(lsu_cfg_t)-1:0]);
    end
  end

  assign cfg_o = cfg_q;

  //////////////////////////////////////////////////
  // Status clear strobes
  //////////////////////////////////////////////////

  // A one written to a status bit becomes a single-cycle clear pulse
  // The flags themselves live in the monitor
  always_comb begin
    flags_clr_o = '0;
    if (cfg_we_i && sel_stat) begin
      flags_clr_o = mon_flags_t'(cfg_wdata_i[$bits(mon_flags_t)-1:0]);
    end
  end

  //////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////

  // Combinational read of whatever cfg_addr_i points at
  // Unmapped addresses read as zero
  always_comb begin
    cfg_rdata_o = '0;
    if (sel_ctrl) begin
      cfg_rdata_o[$bits(lsu_cfg_t)-1:0] = cfg_q;
    end else if (sel_stat) begin
      cfg_rdata_o[$bits(mon_flags_t)-1:0] = flags_i;
    end
  end

endmodule

//--- lsu_ctrl.sv
`include "lsu_macros.svh"

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        valid_i,
  input  lsu_req_t    req_i,
  output logic        ready_o,
  input  lsu_cfg_t    cfg_i,
  output obi_req_t    obi_req_o,
  input  logic        gnt_i,
  input  logic        rvalid_i,
  output split_info_t split_o,
  output logic        trap_o,
  output logic        last_rvalid_o
);

  lsu_state_e              state_q;
  lsu_state_e              state_d;
  lsu_req_t                req_q;
  logic                    split_q;
  logic                    held_q;
  cnt_t                    cnt_q;
  cnt_t                    cnt_d;
  logic                    accept;
  logic                    misaligned;
  logic                    issue;
  logic                    second;
  logic                    bus_req;
  logic                    rvalid_ok;
  be_t                     be_base;
  logic [`LSU_XLEN/4-1:0]  be_wide;
  logic [2*`LSU_XLEN-1:0]  wdata_wide;
  addr_t                   addr_word;

  //////////////////////////////////////////////////
  // Core handshake
  //////////////////////////////////////////////////

  // A halted unit looks busy to the core and takes nothing new
  assign ready_o = (state_q == LSU_IDLE) && !cfg_i.halt;
  assign accept  = valid_i && ready_o;

  // Misalignment is judged on the incoming request so a trap can answer at once
  // Halfwords at offset 1 or 2 still fit in one word and need no split
  always_comb begin
    case (req_i.size)
      SIZE_WORD: misaligned = (req_i.addr[1:0] != 2'b00);
      SIZE_HALF: misaligned = (req_i.addr[1:0] == 2'b11);
      default:   misaligned = 1'b0;
    endcase
  end

  assign trap_o = accept && misaligned && cfg_i.misalign_trap;

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      LSU_IDLE:   if (accept && !trap_o) state_d = LSU_FIRST;
      LSU_FIRST:  if (bus_req && gnt_i) state_d = split_q ? LSU_SECOND : LSU_WAIT;
      LSU_SECOND: if (bus_req && gnt_i) state_d = LSU_WAIT;
      LSU_WAIT:   if (last_rvalid_o) state_d = LSU_IDLE;
      default:    state_d = LSU_IDLE;
    endcase
  end

  // A request already on the bus stays up until granted, even under halt
  // A fresh one waits for halt to drop and for room below the depth limit
  assign issue   = (state_q == LSU_FIRST) || (state_q == LSU_SECOND);
  assign second  = (state_q == LSU_SECOND);
  assign bus_req = issue && (held_q || (!cfg_i.halt && (cnt_q != cnt_t'(`LSU_DEPTH))));

  //////////////////////////////////////////////////
  // Address phase payload
  //////////////////////////////////////////////////

  // Enables and data are laid out over two words, the upper word is the second half
  always_comb begin
    case (req_q.size)
      SIZE_BYTE: be_base = 4'b0001;
      SIZE_HALF: be_base = 4'b0011;
      default:   be_base = 4'b1111;
    endcase
    be_wide    = {4'b0000, be_base} << req_q.addr[1:0];
    wdata_wide = {{`LSU_XLEN{1'b0}}, req_q.wdata} << {req_q.addr[1:0], 3'b000};
  end

  assign addr_word = {req_q.addr[`LSU_XLEN-1:2], 2'b00};

  assign obi_req_o.req   = bus_req;
  assign obi_req_o.we    = req_q.we;
  assign obi_req_o.addr  = second ? addr_word + addr_t'(4) : addr_word;
  assign obi_req_o.be    = second ? be_wide[7:4] : be_wide[3:0];
  assign obi_req_o.wdata = second ? wdata_wide[2*`LSU_XLEN-1:`LSU_XLEN]
                                  : wdata_wide[`LSU_XLEN-1:0];

  //////////////////////////////////////////////////
  // In-flight counter
  //////////////////////////////////////////////////

  // An rvalid with nothing outstanding is dropped here
  assign rvalid_ok = rvalid_i && (cnt_q != '0);

  always_comb begin
    cnt_d = cnt_q;
    if (bus_req && gnt_i) cnt_d = cnt_d + cnt_t'(1);
    if (rvalid_ok)        cnt_d = cnt_d - cnt_t'(1);
  end

  // All grants of the access are done in WAIT, so the last one out ends it
  assign last_rvalid_o = (state_q == LSU_WAIT) && rvalid_ok && (cnt_q == cnt_t'(1));

  // Access shape for the aligner, stable from acceptance to the last rvalid
  assign split_o.split    = split_q;
  assign split_o.addr_low = req_q.addr[1:0];
  assign split_o.size     = req_q.size;
  assign split_o.sign_ext = req_q.sign_ext;
  assign split_o.we       = req_q.we;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= LSU_IDLE;
      cnt_q   <= '0;
      held_q  <= 1'b0;
      split_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      held_q  <= bus_req && !gnt_i;
      if (accept) split_q <= misaligned;
    end
  end

  // Request payload is captured once per access
  always_ff @(posedge clk) begin
    if (accept) req_q <= req_i;
  end

endmodule

//--- lsu_resp_align.sv
`include "lsu_macros.svh"

module lsu_resp_align
  import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  split_info_t split_i,
  input  logic        rvalid_i,
  input  data_t       rdata_i,
  input  logic        last_rvalid_i,
  input  logic        trap_i,
  output logic        resp_valid_o,
  output lsu_resp_t   resp_o
);

  data_t                  first_q;
  logic [2*`LSU_XLEN-1:0] joined;
  data_t                  shifted;
  data_t                  extended;

  //////////////////////////////////////////////////
  // First half capture
  //////////////////////////////////////////////////

  // The lower word of a split access returns first
  always_ff @(posedge clk) begin
    if (rvalid_i && !last_rvalid_i && split_i.split) first_q <= rdata_i;
  end

  //////////////////////////////////////////////////
  // Merge, shift and extend
  //////////////////////////////////////////////////

  // The second word supplies the upper bytes of a split access
  // A single word is padded with zeros above
  assign joined  = split_i.split ? {rdata_i, first_q} : {{`LSU_XLEN{1'b0}}, rdata_i};
  assign shifted = data_t'(joined >> {split_i.addr_low, 3'b000});

  always_comb begin
    case (split_i.size)
      SIZE_BYTE: begin
        extended = {{(`LSU_XLEN-8){split_i.sign_ext & shifted[7]}}, shifted[7:0]};
      end
      SIZE_HALF: begin
        extended = {{(`LSU_XLEN-16){split_i.sign_ext & shifted[15]}}, shifted[15:0]};
      end
      default: begin
        extended = shifted;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Response register
  //////////////////////////////////////////////////

  // One pulse per access, a cycle after the trap or the final rvalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= trap_i || last_rvalid_i;
    end
  end

  // Trapped accesses and stores carry no data back
  always_ff @(posedge clk) begin
    if (trap_i) begin
      resp_o.rdata <= '0;
      resp_o.err   <= 1'b1;
    end else if (last_rvalid_i) begin
      resp_o.rdata <= split_i.we ? '0 : extended;
      resp_o.err   <= 1'b0;
    end
  end

endmodule

//--- lsu_bus_monitor.sv
`include "lsu_macros.svh"

module lsu_bus_monitor
  import lsu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  obi_req_t   obi_req_i,
  input  logic       gnt_i,
  input  logic       rvalid_i,
  input  logic       halt_i,
  input  mon_flags_t flags_clr_i,
  output mon_flags_t flags_o
);

  cnt_t       cnt_q;
  cnt_t       cnt_d;
  logic       pend_q;
  logic       granted;
  logic       new_req;
  mon_flags_t flags_q;
  mon_flags_t flags_set;

  //////////////////////////////////////////////////
  // Shadow in-flight count
  //////////////////////////////////////////////////

  // Built from bus events alone so it can disagree with the sequencer
  assign granted = obi_req_i.req && gnt_i;

  always_comb begin
    cnt_d = cnt_q;
    if (granted && (cnt_q != cnt_t'(`LSU_DEPTH))) cnt_d = cnt_d + cnt_t'(1);
    if (rvalid_i && (cnt_q != '0))                cnt_d = cnt_d - cnt_t'(1);
  end

  // A request counts as new when it was not already waiting for a grant
  assign new_req = obi_req_i.req && !pend_q;

  //////////////////////////////////////////////////
  // Error detection
  //////////////////////////////////////////////////

  always_comb begin
    flags_set = '0;
    // A grant at full depth with no response leaving would pass the limit
    flags_set.cnt_overflow    = granted && !rvalid_i && (cnt_q == cnt_t'(`LSU_DEPTH));
    // Response with nothing outstanding
    flags_set.spurious_rvalid = rvalid_i && (cnt_q == '0);
    // A halted unit must not start a transaction
    flags_set.halt_violation  = new_req && halt_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      pend_q  <= 1'b0;
      flags_q <= '0;
    end else begin
      cnt_q   <= cnt_d;
      pend_q  <= obi_req_i.req && !gnt_i;
      // A new error in the cycle of a clear still sticks
      flags_q <= mon_flags_t'((flags_q & ~flags_clr_i) | flags_set);
    end
  end

  assign flags_o = flags_q;

endmodule

//--- lsu_top.sv
module lsu_top
  import lsu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid_i,
  input  lsu_req_t   req_i,
  output logic       ready_o,
  output logic       resp_valid_o,
  output lsu_resp_t  resp_o,
  output obi_req_t   obi_req_o,
  input  logic       gnt_i,
  input  obi_rsp_t   obi_rsp_i,
  input  logic       cfg_we_i,
  input  logic [1:0] cfg_addr_i,
  input  data_t      cfg_wdata_i,
  output data_t      cfg_rdata_o
);

  lsu_cfg_t    cfg;
  mon_flags_t  flags;
  mon_flags_t  flags_clr;
  split_info_t split;
  logic        trap;
  logic        last_rvalid;

  // Configuration and status registers
  lsu_cfg_regs u_cfg_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .flags_i     (flags),
    .cfg_o       (cfg),
    .flags_clr_o (flags_clr),
    .cfg_rdata_o (cfg_rdata_o)
  );

  // Request sequencer and split logic
  lsu_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .req_i         (req_i),
    .ready_o       (ready_o),
    .cfg_i         (cfg),
    .obi_req_o     (obi_req_o),
    .gnt_i         (gnt_i),
    .rvalid_i      (obi_rsp_i.rvalid),
    .split_o       (split),
    .trap_o        (trap),
    .last_rvalid_o (last_rvalid)
  );

  // Load data merge and extension
  lsu_resp_align u_resp_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .split_i       (split),
    .rvalid_i      (obi_rsp_i.rvalid),
    .rdata_i       (obi_rsp_i.rdata),
    .last_rvalid_i (last_rvalid),
    .trap_i        (trap),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o)
  );

  // Protocol watcher on the data bus
  lsu_bus_monitor u_bus_monitor (
    .clk         (clk),
    .rst_n       (rst_n),
    .obi_req_i   (obi_req_o),
    .gnt_i       (gnt_i),
    .rvalid_i    (obi_rsp_i.rvalid),
    .halt_i      (cfg.halt),
    .flags_clr_i (flags_clr),
    .flags_o     (flags)
  );

endmodule

//--- tb_obi_mem.sv
module tb_obi_mem
  import lsu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  obi_req_t obi_req_i,
  input  logic     inject_spurious_i,
  output logic     gnt_o,
  output obi_rsp_t obi_rsp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  data_t       mem [0:255];
  logic [31:0] lcg_state;
  int          cycle;
  int          gnt_wait;
  logic        wait_drawn;
  logic        spur_pend;
  logic        in_reset;
  int          last_due;
  // Responses wait here in grant order, each with the cycle it is due
  int          due_q [$];
  data_t       data_q [$];

  // Linear congruential step, the upper half of the state is the better half
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  //////////////////////////////////////////////////
  // Bus slave
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    int          due;
    logic [7:0]  idx;
    lcg_state  = 32'ha375_3bc6;
    cycle      = 0;
    gnt_wait   = 0;
    wait_drawn = 1'b0;
    spur_pend  = 1'b0;
    in_reset   = 1'b1;
    last_due   = 0;
    gnt_o      = 1'b0;
    obi_rsp_o  = '0;
    // Every word starts from its own index so each address reads back distinct data
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) * 32'h0101_0101) ^ 32'hA5A5_5A5A;
    end
    forever begin
      // Rising edge, the handshake and the injection request are sampled here
      @(posedge clk);
      cycle++;
      in_reset = !rst_n;
      if (!in_reset) begin
        if (inject_spurious_i) spur_pend = 1'b1;
        if (obi_req_i.req && gnt_o) begin
          idx = obi_req_i.addr[9:2];
          if (obi_req_i.we) begin
            for (int b = 0; b < 4; b++) begin
              if (obi_req_i.be[b]) mem[idx][8*b +: 8] = obi_req_i.wdata[8*b +: 8];
            end
          end
          // Latency of 1 to 3 cycles, never overtaking an older response
          rnd = next_random();
          due = cycle + 1 + int'((rnd >> 16) % 32'd3);
          if (due <= last_due) due = last_due + 1;
          last_due = due;
          due_q.push_back(due);
          data_q.push_back(mem[idx]);
          wait_drawn = 1'b0;
        end
      end
      // Falling edge, outputs for the next rising edge are set up
      @(negedge clk);
      gnt_o     = 1'b0;
      obi_rsp_o = '0;
      if (!in_reset) begin
        if ((due_q.size() > 0) && (due_q[0] <= cycle + 1)) begin
          obi_rsp_o.rvalid = 1'b1;
          obi_rsp_o.rdata  = data_q.pop_front();
          void'(due_q.pop_front());
        end else if (spur_pend && (due_q.size() == 0)) begin
          // A response that belongs to no transaction
          obi_rsp_o.rvalid = 1'b1;
          obi_rsp_o.rdata  = 32'hBAD0_0BAD;
          spur_pend        = 1'b0;
        end
        // Each new request draws its own grant delay of 0 to 2 cycles
        if (obi_req_i.req) begin
          if (!wait_drawn) begin
            rnd        = next_random();
            gnt_wait   = int'((rnd >> 16) % 32'd3);
            wait_drawn = 1'b1;
          end
          if (gnt_wait == 0) begin
            gnt_o = 1'b1;
          end else begin
            gnt_wait--;
          end
        end
      end
    end
  end

endmodule

//--- tb_lsu.sv
`include "lsu_macros.svh"

module tb_lsu
  import lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT     = 200;
  localparam int HALT_CYCLES = 20;
  // Eight words per pattern record
  localparam int PAT_WORDS   = 8 * 64;

  logic        clk;
  logic        rst_n;
  logic        valid;
  lsu_req_t    req;
  logic        ready;
  logic        resp_valid;
  lsu_resp_t   resp;
  obi_req_t    obi_req;
  logic        gnt;
  obi_rsp_t    obi_rsp;
  logic        cfg_we;
  logic [1:0]  cfg_addr;
  data_t       cfg_wdata;
  data_t       cfg_rdata;
  logic        inject_spurious;
  logic [31:0] pat [0:PAT_WORDS-1];
  // Running count of bus responses seen since reset
  int          rsp_total = 0;

  lsu_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid),
    .req_i        (req),
    .ready_o      (ready),
    .resp_valid_o (resp_valid),
    .resp_o       (resp),
    .obi_req_o    (obi_req),
    .gnt_i        (gnt),
    .obi_rsp_i    (obi_rsp),
    .cfg_we_i     (cfg_we),
    .cfg_addr_i   (cfg_addr),
    .cfg_wdata_i  (cfg_wdata),
    .cfg_rdata_o  (cfg_rdata)
  );

  tb_obi_mem u_mem (
    .clk               (clk),
    .rst_n             (rst_n),
    .obi_req_i         (obi_req),
    .inject_spurious_i (inject_spurious),
    .gnt_o             (gnt),
    .obi_rsp_o         (obi_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Every granted transaction of the LSU ends in exactly one rvalid
  always @(posedge clk) begin
    if (rst_n && obi_rsp.rvalid) rsp_total++;
  end

  //////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
    abort_run();
  endtask

  task automatic check_resp(input lsu_resp_t got, input lsu_resp_t want);
    if (got !== want) begin
      $display("error resp_o rdata %h err %h, expected rdata %h err %h",
               got.rdata, got.err, want.rdata, want.err);
      abort_run();
    end
  endtask

  task automatic check_flags(input mon_flags_t got, input mon_flags_t want);
    if (got !== want) begin
      $display("error cfg_rdata_o status flags %h, expected %h", got, want);
      abort_run();
    end
  endtask

  task automatic check_data(input data_t got, input data_t want);
    if (got !== want) begin
      $display("error cfg_rdata_o %h, expected %h", got, want);
      abort_run();
    end
  endtask

  task automatic check_count(input cnt_t got, input cnt_t want);
    if (got !== want) begin
      $display("error obi_req_o transactions per access %h, expected %h", got, want);
      abort_run();
    end
  endtask

  // A trap uses no bus, a misaligned access needs two words, all else one
  function automatic cnt_t expected_txns(input lsu_req_t acc, input lsu_resp_t want);
    if (want.err) return cnt_t'(0);
    if ((acc.size == SIZE_WORD) && (acc.addr[1:0] != 2'b00)) return cnt_t'(2);
    if ((acc.size == SIZE_HALF) && (acc.addr[1:0] == 2'b11)) return cnt_t'(2);
    return cnt_t'(1);
  endfunction

  //////////////////////////////////////////////////
  // Port drivers, entered and left on a falling edge
  //////////////////////////////////////////////////

  task automatic write_cfg(input logic [1:0] addr, input data_t value);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = value;
    @(negedge clk);
    cfg_we    = 1'b0;
    cfg_wdata = '0;
  endtask

  // The read port is combinational, so the value is taken one falling edge later
  task automatic read_check(input logic [1:0] addr, input data_t want);
    cfg_addr = addr;
    @(negedge clk);
    if (addr == 2'(`LSU_CFG_STAT_ADDR)) begin
      check_flags(mon_flags_t'(cfg_rdata[$bits(mon_flags_t)-1:0]),
                  mon_flags_t'(want[$bits(mon_flags_t)-1:0]));
    end else begin
      check_data(cfg_rdata, want);
    end
  endtask

  task automatic run_access(input lsu_req_t acc, input lsu_resp_t want, input logic halted);
    int waited;
    int start;
    start = rsp_total;
    valid = 1'b1;
    req   = acc;
    // While halted the request must sit unanswered, then halt is released
    if (halted) begin
      for (int c = 0; c < HALT_CYCLES; c++) begin
        if (ready || resp_valid) begin
          $display("the LSU answered a request while halt was set");
          abort_run();
        end
        @(negedge clk);
      end
      write_cfg(2'(`LSU_CFG_CTRL_ADDR), '0);
    end
    waited = 0;
    while (!ready) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) report_timeout("ready_o");
    end
    // The rising edge in between took the request
    @(negedge clk);
    valid  = 1'b0;
    req    = '0;
    waited = 0;
    while (!resp_valid) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) report_timeout("resp_valid_o");
    end
    check_resp(resp, want);
    check_count(cnt_t'(rsp_total - start), expected_txns(acc, want));
  endtask

  task automatic inject_spurious_rvalid();
    int waited;
    inject_spurious = 1'b1;
    @(negedge clk);
    inject_spurious = 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) report_timeout("the injected rvalid");
    end while (!obi_rsp.rvalid);
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // Pattern sequencer
  //////////////////////////////////////////////////

  initial begin
    int          base;
    int          n_access;
    logic [31:0] op;
    lsu_req_t    acc;
    lsu_resp_t   want;
    rst_n           = 1'b0;
    valid           = 1'b0;
    req             = '0;
    cfg_we          = 1'b0;
    cfg_addr        = '0;
    cfg_wdata       = '0;
    inject_spurious = 1'b0;
    for (int i = 0; i < PAT_WORDS; i++) pat[i] = '0;
    $readmemh("lsu_patterns.txt", pat);
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    base     = 0;
    n_access = 0;
    // Opcode zero ends the list
    while ((base < PAT_WORDS) && (pat[base] != '0)) begin
      op            = pat[base];
      acc.we        = pat[base+1][0];
      acc.size      = lsu_size_e'(pat[base+2][1:0]);
      acc.sign_ext  = pat[base+3][0];
      acc.addr      = pat[base+4];
      acc.wdata     = pat[base+5];
      want.rdata    = pat[base+6];
      want.err      = pat[base+7][0];
      case (op)
        32'd1: begin
          run_access(acc, want, 1'b0);
          n_access++;
        end
        32'd2: write_cfg(acc.addr[1:0], acc.wdata);
        32'd3: read_check(acc.addr[1:0], want.rdata);
        32'd4: inject_spurious_rvalid();
        32'd5: begin
          run_access(acc, want, 1'b1);
          n_access++;
        end
        default: begin
          $display("unknown opcode %h in record %0d of lsu_patterns.txt", op, base / 8);
          abort_run();
        end
      endcase
      base += 8;
    end
    if (n_access > 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("no load or store records were found in lsu_patterns.txt");
      abort_run();
    end
  end

endmodule

//--- lsu_patterns.txt
// op we size sext addr wdata exp_rdata exp_err, size 0 byte 1 half 2 word
// op 1 access, 2 cfg write, 3 cfg read check, 4 spurious rvalid, 5 access under halt, 0 end
1 0 2 0 00000010 00000000 A1A15E5E 0
1 0 1 0 00000012 00000000 0000A1A1 0
1 0 1 1 00000012 00000000 FFFFA1A1 0
1 0 1 0 00000014 00000000 00005F5F 0
1 0 1 1 00000019 00000000 FFFFA35C 0
1 0 0 1 0000001B 00000000 FFFFFFA3 0
1 0 0 0 0000001B 00000000 000000A3 0
1 0 0 0 00000019 00000000 0000005C 0
1 0 0 1 0000001C 00000000 0000005D 0
1 1 2 0 00000040 12345678 00000000 0
1 0 2 0 00000040 00000000 12345678 0
1 1 0 0 00000041 112233AB 00000000 0
1 0 2 0 00000040 00000000 1234AB78 0
1 1 1 0 00000042 5566CDEF 00000000 0
1 0 2 0 00000040 00000000 CDEFAB78 0
1 0 2 0 00000021 00000000 53ADAD52 0
1 0 1 0 00000023 00000000 000053AD 0
1 0 1 1 00000213 00000000 FFFFDF21 0
1 1 2 0 00000102 DEADBEEF 00000000 0
1 0 2 0 00000100 00000000 BEEF1A1A 0
1 0 2 0 00000104 00000000 E4E4DEAD 0
1 0 2 0 00000102 00000000 DEADBEEF 0
1 1 1 0 0000010B 0000BEEF 00000000 0
1 0 1 1 0000010B 00000000 FFFFBEEF 0
1 0 2 0 0000010C 00000000 E6E619BE 0
2 0 0 0 00000000 00000001 00000000 0
3 0 0 0 00000000 00000000 00000001 0
1 0 2 0 00000021 00000000 00000000 1
1 1 1 0 00000107 0000FFFF 00000000 1
1 0 2 0 00000020 00000000 ADAD5252 0
1 0 2 0 00000104 00000000 E4E4DEAD 0
1 0 2 0 00000108 00000000 EFE71818 0
1 0 1 1 00000012 00000000 FFFFA1A1 0
2 0 0 0 00000000 00000000 00000000 0
2 0 0 0 00000000 00000002 00000000 0
3 0 0 0 00000000 00000000 00000002 0
5 0 2 0 00000084 00000000 84847B7B 0
3 0 0 0 00000000 00000000 00000000 0
3 0 0 0 00000001 00000000 00000000 0
4 0 0 0 00000000 00000000 00000000 0
3 0 0 0 00000001 00000000 00000002 0
2 0 0 0 00000001 00000007 00000000 0
3 0 0 0 00000001 00000000 00000000 0
1 0 2 0 00000010 00000000 A1A15E5E 0
0 0 0 0 00000000 00000000 00000000 0

//--- compile.f
+incdir+.
lsu_pkg.sv
lsu_cfg_regs.sv
lsu_ctrl.sv
lsu_resp_align.sv
lsu_bus_monitor.sv
lsu_top.sv
tb_obi_mem.sv
tb_lsu.sv

//--- run_sim.sh
#!/bin/sh
# Builds the LSU testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --top-module tb_lsu -f compile.f --Mdir obj_dir -o tb_lsu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

# The log decides the result, a nonzero exit status is reported as well
if grep -q "Testbench failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
